/* src/bm_pkg.sv */
package bm_pkg;

    // Symbol width of GF(2^8)
    localparam int GF_WIDTH = 8;

    // x^8 + x^4 + x^3 + x^2 + 1
    localparam logic [GF_WIDTH:0] GF_POLY = 9'h11D;

    typedef logic [GF_WIDTH-1:0] gf_elem_t;

    // Solver controller states
    typedef enum logic [1:0]
    {
        ST_IDLE = 2'd0,  // Waiting for a request
        ST_LOAD = 2'd1,  // Capture syndromes, seed polynomials
        ST_ITER = 2'd2,  // One Berlekamp-Massey step per cycle
        ST_DONE = 2'd3   // Result valid, handshake closing
    } bm_state_t;

endpackage

/* src/gf_mult.sv */
`timescale 1ns/1ps

module gf_mult
    import bm_pkg::*;
(
    input  gf_elem_t i_a,
    input  gf_elem_t i_b,
    output gf_elem_t o_p
);
    localparam int PROD_W = 2 * GF_WIDTH - 1;

    logic [PROD_W-1:0] prod;

    always_comb
    begin
        prod = '0;
        for (int i = 0; i < GF_WIDTH; i++)
        begin
            if (i_b[i])
                prod = prod ^ (PROD_W'(i_a) << i);  // Carry-less partial product
        end
        // Fold the high bits back, top bit first
        for (int i = PROD_W - 1; i >= GF_WIDTH; i--)
        begin
            if (prod[i])
                prod = prod ^ (PROD_W'(GF_POLY) << (i - GF_WIDTH));
        end
    end

    assign o_p = prod[GF_WIDTH-1:0];

endmodule

/* src/gf_inverse.sv */
`timescale 1ns/1ps

module gf_inverse
    import bm_pkg::*;
(
    input  gf_elem_t i_x,
    output gf_elem_t o_inv
);
    // x^-1 = x^254 and 254 = 2 + 4 + 8 + ... + 128
    localparam int N_SQ = GF_WIDTH - 1;

    gf_elem_t sq  [N_SQ+1];  // sq[i] = x^(2^i)
    gf_elem_t acc [1:N_SQ];  // acc[i] = x^(2 + 4 + ... + 2^i)

    assign sq[0] = i_x;

    for (genvar i = 1; i <= N_SQ; i++)
    begin : g_square
        gf_mult u_sq
        (
            .i_a (sq[i-1]),
            .i_b (sq[i-1]),
            .o_p (sq[i])
        );
    end

    assign acc[1] = sq[1];

    for (genvar i = 2; i <= N_SQ; i++)
    begin : g_product
        gf_mult u_mul
        (
            .i_a (acc[i-1]),
            .i_b (sq[i]),
            .o_p (acc[i])
        );
    end

    assign o_inv = acc[N_SQ];  // Zero maps to zero

endmodule

/* src/bm_discrepancy.sv */
`timescale 1ns/1ps

module bm_discrepancy
    import bm_pkg::*;
#(
    parameter  int T_CORR = 3,
    localparam int K_W    = $clog2(2 * T_CORR)
)
(
    input  gf_elem_t       i_synd  [2*T_CORR],
    input  gf_elem_t       i_sigma [T_CORR+1],
    input  logic [K_W-1:0] i_k,
    output gf_elem_t       o_delta
);
    gf_elem_t synd_sel [T_CORR+1];  // S[k-i], zero when k < i
    gf_elem_t term     [T_CORR+1];  // sigma_i * S[k-i]

    always_comb
    begin
        for (int i = 0; i <= T_CORR; i++)
        begin
            synd_sel[i] = '0;
            for (int s = 0; s < 2 * T_CORR; s++)
            begin
                if (s + i == int'(i_k))
                    synd_sel[i] = i_synd[s];
            end
        end
    end

    // Sigma_0 is held at one and needs no multiplier
    assign term[0] = {GF_WIDTH{i_sigma[0][0]}} & synd_sel[0];

    for (genvar i = 1; i <= T_CORR; i++)
    begin : g_term
        gf_mult u_mul
        (
            .i_a (i_sigma[i]),
            .i_b (synd_sel[i]),
            .o_p (term[i])
        );
    end

    // Coefficients above L are zero, so summing all of them is safe
    always_comb
    begin
        o_delta = term[0];
        for (int i = 1; i <= T_CORR; i++)
        begin
            o_delta = o_delta ^ term[i];  // GF addition
        end
    end

endmodule

/* src/bm_poly_update.sv */
`timescale 1ns/1ps

module bm_poly_update
    import bm_pkg::*;
#(
    parameter  int T_CORR = 3,
    localparam int K_W    = $clog2(2 * T_CORR),
    localparam int D_W    = $clog2(2 * T_CORR + 1)
)
(
    input  logic           i_clock,
    input  logic           i_rst,
    input  logic           i_load,
    input  logic           i_step,
    input  logic [K_W-1:0] i_k,
    input  gf_elem_t       i_delta,
    output gf_elem_t       o_sigma [T_CORR+1],
    output logic [D_W-1:0] o_degree
);
    localparam int M_W = $clog2(2 * T_CORR + 2);

    gf_elem_t       sigma_q  [T_CORR+1];
    gf_elem_t       b_poly_q [T_CORR+1];  // Correction polynomial B
    gf_elem_t       b_prev_q;             // Discrepancy at the last length change
    logic [D_W-1:0] l_q;
    logic [M_W-1:0] m_q;                  // Shift of B against sigma

    gf_elem_t b_inv;
    gf_elem_t coef;                       // delta / b
    gf_elem_t shifted [T_CORR+1];         // x^m * B, truncated to the sigma size
    gf_elem_t corr    [T_CORR+1];
    logic     delta_nz;
    logic     grow;

    assign delta_nz = (i_delta != '0);
    assign grow     = (2 * int'(l_q) <= int'(i_k));  // Length change when 2L <= k

    always_comb
    begin
        for (int j = 0; j <= T_CORR; j++)
        begin
            shifted[j] = '0;
            for (int i = 0; i <= T_CORR; i++)
            begin
                if (i + int'(m_q) == j)
                    shifted[j] = b_poly_q[i];
            end
        end
    end

    gf_inverse u_b_inv
    (
        .i_x   (b_prev_q),
        .o_inv (b_inv)
    );

    gf_mult u_coef
    (
        .i_a (i_delta),
        .i_b (b_inv),
        .o_p (coef)
    );

    for (genvar j = 0; j <= T_CORR; j++)
    begin : g_corr
        gf_mult u_mul
        (
            .i_a (coef),
            .i_b (shifted[j]),
            .o_p (corr[j])
        );
    end

    always_ff @(posedge i_clock)
    begin
        if (i_rst || i_load)
        begin
            for (int j = 0; j <= T_CORR; j++)
            begin
                sigma_q[j] <= (j == 0) ? gf_elem_t'(1) : '0;
            end
            l_q <= '0;
        end
        else if (i_step && delta_nz)
        begin
            for (int j = 0; j <= T_CORR; j++)
            begin
                sigma_q[j] <= sigma_q[j] ^ corr[j];
            end
            if (grow)
                l_q <= D_W'(int'(i_k) + 1 - int'(l_q));  // L = k + 1 - L
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_load)
        begin
            for (int j = 0; j <= T_CORR; j++)
            begin
                b_poly_q[j] <= (j == 0) ? gf_elem_t'(1) : '0;
            end
            m_q      <= M_W'(1);
            b_prev_q <= gf_elem_t'(1);
        end
        else if (i_step)
        begin
            if (delta_nz && grow)
            begin
                b_poly_q <= sigma_q;  // Old sigma becomes the new B
                m_q      <= M_W'(1);
                b_prev_q <= i_delta;
            end
            else
                m_q <= m_q + 1'b1;
        end
    end

    assign o_sigma  = sigma_q;
    assign o_degree = l_q;

endmodule

/* src/bm_control.sv */
`timescale 1ns/1ps

module bm_control
    import bm_pkg::*;
#(
    parameter  int T_CORR = 3,
    localparam int K_W    = $clog2(2 * T_CORR)
)
(
    input  logic           i_clock,
    input  logic           i_rst,
    input  logic           i_req,
    output logic           o_ack,
    output logic           o_load,
    output logic           o_step,
    output logic [K_W-1:0] o_k
);
    localparam logic [K_W-1:0] K_LAST = K_W'(2 * T_CORR - 1);

    bm_state_t      state;
    logic [K_W-1:0] k_q;

    always_ff @(posedge i_clock)
    begin
        if (i_rst)
        begin
            state <= ST_IDLE;
            k_q   <= '0;
            o_ack <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    o_ack <= 1'b0;
                    if (i_req)
                        state <= ST_LOAD;
                end
                ST_LOAD:
                begin
                    k_q   <= '0;
                    state <= ST_ITER;
                end
                ST_ITER:
                begin
                    k_q <= k_q + 1'b1;
                    if (k_q == K_LAST)
                        state <= ST_DONE;  // Last step lands on this edge
                end
                ST_DONE:
                begin
                    // Ack follows the request until it drops
                    o_ack <= i_req;
                    if (!i_req)
                        state <= ST_IDLE;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign o_load = (state == ST_LOAD);
    assign o_step = (state == ST_ITER);
    assign o_k    = k_q;

endmodule

/* src/bm_solver.sv */
`timescale 1ns/1ps

module bm_solver
    import bm_pkg::*;
#(
    parameter  int T_CORR = 3,
    localparam int K_W    = $clog2(2 * T_CORR),
    localparam int D_W    = $clog2(2 * T_CORR + 1)
)
(
    input  logic           i_clock,
    input  logic           i_rst,
    input  logic           i_req,
    input  gf_elem_t       i_synd   [2*T_CORR],
    output logic           o_ack,
    output gf_elem_t       o_sigma  [T_CORR+1],
    output logic [D_W-1:0] o_degree
);
    gf_elem_t       synd_q [2*T_CORR];  // Held for the whole solve
    logic           load;
    logic           step;
    logic [K_W-1:0] k;
    gf_elem_t       delta;

    // i_synd is stable while i_req is high, so capture on the load cycle
    always_ff @(posedge i_clock)
    begin
        if (load)
            synd_q <= i_synd;
    end

    bm_control #(.T_CORR(T_CORR)) u_control
    (
        .i_clock (i_clock),
        .i_rst   (i_rst),
        .i_req   (i_req),
        .o_ack   (o_ack),
        .o_load  (load),
        .o_step  (step),
        .o_k     (k)
    );

    bm_discrepancy #(.T_CORR(T_CORR)) u_discrepancy
    (
        .i_synd  (synd_q),
        .i_sigma (o_sigma),
        .i_k     (k),
        .o_delta (delta)
    );

    bm_poly_update #(.T_CORR(T_CORR)) u_poly_update
    (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_load   (load),
        .i_step   (step),
        .i_k      (k),
        .i_delta  (delta),
        .o_sigma  (o_sigma),
        .o_degree (o_degree)
    );

endmodule

/* testbench/bm_solver_properties.sv */
`timescale 1ns/1ps

module bm_solver_properties
    import bm_pkg::*;
#(
    parameter  int T_CORR = 3,
    localparam int D_W    = $clog2(2 * T_CORR + 1)
)
(
    input logic           i_clock,
    input logic           i_rst,
    input logic           i_req,
    input logic           o_ack,
    input gf_elem_t       o_sigma [T_CORR+1],
    input logic [D_W-1:0] o_degree
);
    logic [(T_CORR+1)*GF_WIDTH-1:0] sigma_flat;  // Packed copy for $stable

    always_comb
    begin
        for (int j = 0; j <= T_CORR; j++)
        begin
            sigma_flat[j*GF_WIDTH +: GF_WIDTH] = o_sigma[j];
        end
    end

    ack_needs_req: assert property (@(posedge i_clock) disable iff (i_rst)
        $rose(o_ack) |-> $past(i_req))
        else $error("o_ack rose although i_req was low");

    ack_held_by_req: assert property (@(posedge i_clock) disable iff (i_rst)
        (o_ack && i_req) |=> o_ack)
        else $error("o_ack fell while i_req was still high");

    result_stable: assert property (@(posedge i_clock) disable iff (i_rst)
        o_ack |=> ($stable(sigma_flat) && $stable(o_degree)))
        else $error("o_sigma or o_degree changed while o_ack was high");

endmodule

bind bm_solver bm_solver_properties #(.T_CORR(T_CORR)) u_properties
(
    .i_clock  (i_clock),
    .i_rst    (i_rst),
    .i_req    (i_req),
    .o_ack    (o_ack),
    .o_sigma  (o_sigma),
    .o_degree (o_degree)
);

/* testbench/bm_solver_tb.sv */
`timescale 1ns/1ps

module bm_solver_tb
    import bm_pkg::*;
();
    localparam int T_CORR  = 3;
    localparam int N_SYND  = 2 * T_CORR;
    localparam int D_W     = $clog2(2 * T_CORR + 1);
    localparam int N_TAB   = 8;
    localparam int N_RAND  = 20;
    localparam int TIMEOUT = 50;  // Clock edges allowed per wait

    logic           i_clock;
    logic           i_rst;
    logic           i_req;
    gf_elem_t       i_synd  [N_SYND];
    logic           o_ack;
    gf_elem_t       o_sigma [T_CORR+1];
    logic [D_W-1:0] o_degree;

    string    tab_name [N_TAB];
    gf_elem_t tab_loc  [N_TAB][T_CORR];  // Error locators X_j
    gf_elem_t tab_val  [N_TAB][T_CORR];  // Error values e_j
    int       tab_cnt  [N_TAB];
    int       tab_hold [N_TAB];          // Extra cycles with i_req held

    int seed       = 32'h8c16;
    int err_count  = 0;
    int pass_count = 0;
    int fail_count = 0;

    bm_solver #(.T_CORR(T_CORR)) dut_i
    (
        .i_clock  (i_clock),
        .i_rst    (i_rst),
        .i_req    (i_req),
        .i_synd   (i_synd),
        .o_ack    (o_ack),
        .o_sigma  (o_sigma),
        .o_degree (o_degree)
    );

    initial i_clock = 1'b0;
    always #5 i_clock = ~i_clock;

    // Shift-and-reduce multiply, one bit of b per round
    function automatic gf_elem_t gf_mul_ref(input gf_elem_t a, input gf_elem_t b);
        logic [GF_WIDTH:0] sh;
        gf_elem_t          r;
        sh = {1'b0, a};
        r  = '0;
        for (int i = 0; i < GF_WIDTH; i++)
        begin
            if (b[i])
                r = r ^ sh[GF_WIDTH-1:0];
            sh = sh << 1;
            if (sh[GF_WIDTH])
                sh = sh ^ GF_POLY;
        end
        return r;
    endfunction

    function automatic gf_elem_t gf_pow_ref(input gf_elem_t x, input int n);
        gf_elem_t r;
        r = 8'h01;
        for (int i = 0; i < n; i++)
        begin
            r = gf_mul_ref(r, x);
        end
        return r;
    endfunction

    function automatic bit is_taken(input gf_elem_t loc [T_CORR], input int n, input gf_elem_t x);
        for (int i = 0; i < n; i++)
        begin
            if (loc[i] == x)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic compare_elem(input string test, input string what,
                                input gf_elem_t exp, input gf_elem_t act);
        if (act !== exp)
        begin
            $display("Error %s %s: expected %02h, actual %02h", test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_degree(input string test, input logic [D_W-1:0] exp,
                                  input logic [D_W-1:0] act);
        if (act !== exp)
        begin
            $display("Error %s degree: expected %0d, actual %0d", test, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_count(input string test, input string what, input int exp, input int act);
        if (act != exp)
        begin
            $display("Error %s %s: expected %0d, actual %0d", test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic report_result(input string test, input int errs_before);
        if (err_count == errs_before)
        begin
            pass_count++;
            $display("PASS %s", test);
        end
        else
        begin
            fail_count++;
            $display("FAIL %s", test);
        end
    endtask

    task automatic set_entry(input int idx, input string name, input int cnt, input int hold,
                             input gf_elem_t x0, input gf_elem_t x1, input gf_elem_t x2,
                             input gf_elem_t e0, input gf_elem_t e1, input gf_elem_t e2);
        tab_name[idx]   = name;
        tab_cnt[idx]    = cnt;
        tab_hold[idx]   = hold;
        tab_loc[idx][0] = x0;
        tab_loc[idx][1] = x1;
        tab_loc[idx][2] = x2;
        tab_val[idx][0] = e0;
        tab_val[idx][1] = e1;
        tab_val[idx][2] = e2;
    endtask

    // Called 1 ns after a rising edge, returns at the same point
    task automatic run_case(input string name, input gf_elem_t loc [T_CORR],
                            input gf_elem_t val [T_CORR], input int cnt, input int hold);
        gf_elem_t exp_sigma [T_CORR+1];
        gf_elem_t s;
        int       errs_before;
        int       edges;
        logic     acked;
        errs_before = err_count;
        for (int i = 0; i < N_SYND; i++)
        begin
            s = '0;
            for (int j = 0; j < cnt; j++)
            begin
                s = s ^ gf_mul_ref(val[j], gf_pow_ref(loc[j], i + 1));  // S_i = sum e_j X_j^(i+1)
            end
            i_synd[i] = s;
        end
        exp_sigma[0] = 8'h01;
        for (int d = 1; d <= T_CORR; d++)
        begin
            exp_sigma[d] = '0;
        end
        for (int j = 0; j < cnt; j++)
        begin
            for (int d = T_CORR; d >= 1; d--)
            begin
                exp_sigma[d] = exp_sigma[d] ^ gf_mul_ref(loc[j], exp_sigma[d-1]);  // Times (1 + X_j z)
            end
        end
        i_req = 1'b1;
        edges = 0;
        acked = 1'b0;
        while (!acked && edges < TIMEOUT)
        begin
            @(posedge i_clock);
            #1;
            edges++;
            acked = o_ack;
        end
        if (!acked)
        begin
            $display("Test %s: o_ack did not rise within %0d clock edges", name, TIMEOUT);
            err_count++;
        end
        else
        begin
            compare_count(name, "ack latency", 2 * T_CORR + 2, edges - 1);
            for (int c = 0; c < hold; c++)
            begin
                @(posedge i_clock);
                #1;
                if (!o_ack)
                begin
                    $display("Test %s: o_ack dropped while i_req was held high", name);
                    err_count++;
                end
            end
            for (int d = 0; d <= T_CORR; d++)
            begin
                compare_elem(name, $sformatf("sigma%0d", d), exp_sigma[d], o_sigma[d]);
            end
            compare_degree(name, D_W'(cnt), o_degree);
        end
        i_req = 1'b0;
        edges = 0;
        while (o_ack && edges < TIMEOUT)
        begin
            @(posedge i_clock);
            #1;
            edges++;
        end
        if (o_ack)
        begin
            $display("Test %s: o_ack stayed high after i_req was released", name);
            err_count++;
        end
        report_result(name, errs_before);
    endtask

    initial
    begin
        gf_elem_t rnd_loc [T_CORR];
        gf_elem_t rnd_val [T_CORR];
        gf_elem_t x;
        int       rnd_cnt;
        int       errs_before;
        i_rst = 1'b1;
        i_req = 1'b0;
        for (int i = 0; i < N_SYND; i++)
        begin
            i_synd[i] = '0;
        end
        set_entry(0, "zero_syndromes", 0, 0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00);
        set_entry(1, "single_x02", 1, 0, 8'h02, 8'h00, 8'h00, 8'h01, 8'h00, 8'h00);
        set_entry(2, "single_x80", 1, 0, 8'h80, 8'h00, 8'h00, 8'h5a, 8'h00, 8'h00);
        set_entry(3, "single_x1d", 1, 0, 8'h1d, 8'h00, 8'h00, 8'hff, 8'h00, 8'h00);
        set_entry(4, "double_a", 2, 0, 8'h03, 8'h07, 8'h00, 8'h11, 8'h22, 8'h00);
        set_entry(5, "double_b", 2, 0, 8'h8e, 8'h47, 8'h00, 8'h01, 8'hc3, 8'h00);
        set_entry(6, "triple_held_req", 3, 20, 8'h02, 8'h04, 8'h08, 8'h01, 8'h02, 8'h03);
        set_entry(7, "triple_b", 3, 0, 8'h55, 8'haa, 8'h13, 8'h9c, 8'h01, 8'h7e);

        repeat (8) @(posedge i_clock);
        #1;
        i_rst = 1'b0;

        errs_before = err_count;
        if (o_ack !== 1'b0)
        begin
            $display("Test reset: o_ack is not low after reset");
            err_count++;
        end
        for (int d = 0; d <= T_CORR; d++)
        begin
            compare_elem("reset", $sformatf("sigma%0d", d), (d == 0) ? 8'h01 : 8'h00, o_sigma[d]);
        end
        compare_degree("reset", '0, o_degree);
        report_result("reset", errs_before);

        for (int t = 0; t < N_TAB; t++)
        begin
            run_case(tab_name[t], tab_loc[t], tab_val[t], tab_cnt[t], tab_hold[t]);
            repeat (2) @(posedge i_clock);
            #1;
        end

        // Back to back, each request follows the fall of o_ack directly
        for (int r = 0; r < N_RAND; r++)
        begin
            rnd_cnt = 1 + int'($unsigned($random(seed)) % 3);
            for (int j = 0; j < T_CORR; j++)
            begin
                rnd_loc[j] = '0;
                rnd_val[j] = '0;
            end
            for (int j = 0; j < rnd_cnt; j++)
            begin
                x = gf_elem_t'($random(seed));
                while (x == 8'h00 || is_taken(rnd_loc, j, x))
                    x = x + 8'h01;
                rnd_loc[j] = x;
                rnd_val[j] = gf_elem_t'($random(seed));
                if (rnd_val[j] == 8'h00)
                    rnd_val[j] = 8'h01;
            end
            run_case($sformatf("random_%0d", r), rnd_loc, rnd_val, rnd_cnt, 0);
        end

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* bm_solver.f */
src/bm_pkg.sv
src/gf_mult.sv
src/gf_inverse.sv
src/bm_discrepancy.sv
src/bm_poly_update.sv
src/bm_control.sv
src/bm_solver.sv
testbench/bm_solver_properties.sv
testbench/bm_solver_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build the Berlekamp-Massey solver testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f bm_solver.f \
    --top-module bm_solver_tb \
    -Mdir obj_dir -o bm_solver_sim

./obj_dir/bm_solver_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"
